// File: rtl/sdp_rdma_pkg.sv
package sdp_rdma_pkg;

  // ========================================
  // widths
  // ========================================
  // log2 of the 8-byte atom
  localparam int atom_shift = 3;

  // channel, height, width minus one
  typedef logic [12:0] dim_t;
  // channel-group counter
  typedef logic [10:0] cgrp_t;
  // atom address, byte address without the low 3 bits
  typedef logic [28:0] line_addr_t;
  typedef logic [31:0] dma_addr_t;
  // size in atoms minus one
  typedef logic [14:0] dma_size_t;
  typedef logic [31:0] stall_cnt_t;

  // fp16 walks the cube like int16
  typedef enum logic [1:0] {
    int8  = 2'd0,
    int16 = 2'd1,
    fp16  = 2'd2
  } precision_e;

  // ========================================
  // structs
  // ========================================
  // operation settings, steady while an op runs
  typedef struct packed {
    logic       op_en;
    logic       perf_dma_en;
    precision_e precision;
    logic       data_mode_per_kernel;
    logic       data_size_1byte;
    logic       data_use_both;
    dim_t       channel;
    dim_t       height;
    dim_t       width;
    line_addr_t base_addr;
    line_addr_t line_stride;
    line_addr_t surf_stride;
  } rdma_cfg_t;

  // dma read request, 47 bits
  typedef struct packed {
    dma_addr_t addr;
    dma_size_t size;
  } dma_req_t;

  // context entry for the egress side, 16 bits
  typedef struct packed {
    logic      cube_end;
    dma_size_t size;
  } ctx_entry_t;

endpackage

// File: rtl/sdp_rdma_cube_walker.sv
module sdp_rdma_cube_walker import sdp_rdma_pkg::*; (
  input  logic       autosa_core_clk,
  input  logic       autosa_core_rstn,
  input  logic       op_load,
  input  rdma_cfg_t  cfg,
  input  logic       dma_req_rdy,
  input  logic       ctx_full,
  output dma_req_t   dma_req,
  output logic       dma_req_vld,
  output logic       req_accept,
  output ctx_entry_t entry,
  output stall_cnt_t rdma_stall
);

  logic       op_active;
  cgrp_t      count_c;
  dim_t       count_h;
  line_addr_t base_addr_line;
  line_addr_t base_addr_surf;
  cgrp_t      size_of_surf;
  logic [1:0] mult_shift;
  dma_size_t  mult_fill;
  dma_size_t  size_of_width;
  dma_size_t  size_of_straight;
  dma_size_t  req_size;
  logic       prec_int8;
  logic       mode_1x1_pack;
  logic       is_last_c;
  logic       is_last_h;
  logic       is_surf_end;
  logic       is_cube_end;
  stall_cnt_t stall_cnt;

  // ========================================
  // config decode
  // ========================================
  assign prec_int8     = (cfg.precision == int8);
  // whole cube fits in one line
  assign mode_1x1_pack = (cfg.width == '0) && (cfg.height == '0);

  // channel groups minus one
  // int8 packs 8 channels per atom, others 4
  always_comb begin
    if (prec_int8) begin
      size_of_surf = cgrp_t'(cfg.channel >> 3);
    end else begin
      size_of_surf = cgrp_t'(cfg.channel >> 2);
    end
  end

  // element multiplier as a shift
  // int8: 1B single x1, 2B single x2, 1B both x2, 2B both x4
  // int16/fp16: single x1, both x2
  always_comb begin
    if (prec_int8) begin
      if (cfg.data_use_both) begin
        mult_shift = cfg.data_size_1byte ? 2'd1 : 2'd2;
      end else begin
        mult_shift = cfg.data_size_1byte ? 2'd0 : 2'd1;
      end
    end else begin
      mult_shift = cfg.data_use_both ? 2'd1 : 2'd0;
    end
  end

  // low ones of (n+1)*m-1 after the shift
  always_comb begin
    case (mult_shift)
      2'd1:    mult_fill = dma_size_t'(1);
      2'd2:    mult_fill = dma_size_t'(3);
      default: mult_fill = '0;
    endcase
  end

  assign size_of_width    = (dma_size_t'(cfg.width) << mult_shift) | mult_fill;
  assign size_of_straight = (dma_size_t'(size_of_surf) << mult_shift) | mult_fill;

  // per kernel and 1x1 pack read the whole cube in one go
  always_comb begin
    if (cfg.data_mode_per_kernel || mode_1x1_pack) begin
      req_size = size_of_straight;
    end else begin
      req_size = size_of_width;
    end
  end

  // ========================================
  // cube shape
  // ========================================
  assign is_last_h   = (count_h == cfg.height);
  assign is_last_c   = (count_c == size_of_surf);
  assign is_surf_end = cfg.data_mode_per_kernel | mode_1x1_pack | is_last_h;
  assign is_cube_end = cfg.data_mode_per_kernel | mode_1x1_pack | (is_last_h & is_last_c);

  // ========================================
  // op control and handshake
  // ========================================
  // hold off while the context queue has no room
  assign dma_req_vld = op_active & ~ctx_full;
  assign req_accept  = dma_req_vld & dma_req_rdy;

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      op_active <= 1'b0;
    end else if (op_load) begin
      op_active <= 1'b1;
    end else if (req_accept && is_cube_end) begin
      op_active <= 1'b0;
    end
  end

  // channel group outer, line inner
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      count_c <= '0;
      count_h <= '0;
    end else if (op_load) begin
      count_c <= '0;
      count_h <= '0;
    end else if (req_accept) begin
      if (is_cube_end) begin
        count_c <= '0;
      end else if (is_surf_end) begin
        count_c <= count_c + 1'b1;
      end
      if (is_surf_end) begin
        count_h <= '0;
      end else begin
        count_h <= count_h + 1'b1;
      end
    end
  end

  // ========================================
  // address stepping
  // ========================================
  // surf base marks the start of the current channel group
  // line base steps by line stride inside it
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      base_addr_line <= '0;
      base_addr_surf <= '0;
    end else if (op_load) begin
      base_addr_line <= cfg.base_addr;
      base_addr_surf <= cfg.base_addr;
    end else if (req_accept) begin
      if (is_surf_end) begin
        base_addr_line <= base_addr_surf + cfg.surf_stride;
        base_addr_surf <= base_addr_surf + cfg.surf_stride;
      end else begin
        base_addr_line <= base_addr_line + cfg.line_stride;
      end
    end
  end

  assign dma_req.addr = {base_addr_line, {atom_shift{1'b0}}};
  assign dma_req.size = req_size;

  // same size goes to egress with the end flag
  assign entry.cube_end = is_cube_end;
  assign entry.size     = req_size;

  // ========================================
  // stall counter
  // ========================================
  // cleared by a new load, wraps at 2^32
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      stall_cnt <= '0;
    end else if (cfg.op_en && cfg.perf_dma_en) begin
      if (op_load) begin
        stall_cnt <= '0;
      end else if (dma_req_vld && !dma_req_rdy) begin
        stall_cnt <= stall_cnt + 1'b1;
      end
    end
  end

  assign rdma_stall = stall_cnt;

endmodule

// File: rtl/sdp_rdma_ctx_fifo.sv
module sdp_rdma_ctx_fifo import sdp_rdma_pkg::*; #(
  parameter int ctx_depth = 4
) (
  input  logic       autosa_core_clk,
  input  logic       autosa_core_rstn,
  input  logic       req_accept,
  input  ctx_entry_t entry,
  input  logic       ctx_rdy,
  output logic       ctx_full,
  output ctx_entry_t ctx,
  output logic       ctx_vld
);

  localparam int idx_w = (ctx_depth > 1) ? $clog2(ctx_depth) : 1;

  // msb is the wrap bit, rest indexes the array
  typedef logic [idx_w:0] ptr_t;

  ctx_entry_t mem [ctx_depth];
  ptr_t       wr_ptr;
  ptr_t       rd_ptr;
  logic       do_pop;

  // step index, flip wrap bit at the last slot
  function automatic ptr_t ptr_next(input ptr_t p);
    ptr_t n;
    if (p[idx_w-1:0] == idx_w'(ctx_depth - 1)) begin
      n = {~p[idx_w], {idx_w{1'b0}}};
    end else begin
      n = p + 1'b1;
    end
    return n;
  endfunction

  // same index, different lap
  assign ctx_full = (wr_ptr[idx_w-1:0] == rd_ptr[idx_w-1:0]) &&
                    (wr_ptr[idx_w] != rd_ptr[idx_w]);
  assign ctx_vld  = (wr_ptr != rd_ptr);
  assign do_pop   = ctx_vld & ctx_rdy;
  assign ctx      = mem[rd_ptr[idx_w-1:0]];

  // entry storage
  always_ff @(posedge autosa_core_clk) begin
    if (req_accept) begin
      mem[wr_ptr[idx_w-1:0]] <= entry;
    end
  end

  // push and pop may share a cycle
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (req_accept) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
    end
  end

endmodule

// File: rtl/sdp_rdma_ig.sv
module sdp_rdma_ig import sdp_rdma_pkg::*; #(
  parameter int ctx_depth = 4
) (
  input  logic       autosa_core_clk,
  input  logic       autosa_core_rstn,
  input  logic       op_load,
  input  rdma_cfg_t  cfg,
  // dma read request port
  output dma_req_t   dma_req,
  output logic       dma_req_vld,
  input  logic       dma_req_rdy,
  // context port to egress
  output ctx_entry_t ctx,
  output logic       ctx_vld,
  input  logic       ctx_rdy,
  // perf
  output stall_cnt_t rdma_stall
);

  // ========================================
  // walker to context queue
  // ========================================
  logic       req_accept;
  ctx_entry_t entry;
  logic       ctx_full;

  // issues one read per line or one per cube
  sdp_rdma_cube_walker u_walker (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .op_load          (op_load),
    .cfg              (cfg),
    .dma_req_rdy      (dma_req_rdy),
    .ctx_full         (ctx_full),
    .dma_req          (dma_req),
    .dma_req_vld      (dma_req_vld),
    .req_accept       (req_accept),
    .entry            (entry),
    .rdma_stall       (rdma_stall)
  );

  // one entry per accepted request
  // full back-pressures the walker
  sdp_rdma_ctx_fifo #(
    .ctx_depth (ctx_depth)
  ) u_ctx_fifo (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .req_accept       (req_accept),
    .entry            (entry),
    .ctx_rdy          (ctx_rdy),
    .ctx_full         (ctx_full),
    .ctx              (ctx),
    .ctx_vld          (ctx_vld)
  );

endmodule

// File: verification/sdp_rdma_ig_checker.sv
module sdp_rdma_ig_checker import sdp_rdma_pkg::*; #(
  parameter int ctx_depth = 4
) (
  input logic     autosa_core_clk,
  input logic     autosa_core_rstn,
  input logic     op_load,
  input dma_req_t dma_req,
  input logic     dma_req_vld,
  input logic     dma_req_rdy,
  input logic     req_accept,
  input logic     ctx_vld,
  input logic     ctx_rdy
);
  timeunit 1ns;
  timeprecision 1ps;

  // entries in the context queue, counted from its write and egress sides
  int occupancy;

  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      occupancy <= 0;
    end else if (req_accept && !(ctx_vld && ctx_rdy)) begin
      occupancy <= occupancy + 1;
    end else if (!req_accept && ctx_vld && ctx_rdy) begin
      occupancy <= occupancy - 1;
    end
  end

  // ========================================
  // request handshake
  // ========================================
  // no request while the context queue is full
  vld_not_full: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    dma_req_vld |-> occupancy < ctx_depth)
    else $error("dma_req_vld high with the context queue full");

  // payload held while stalled
  payload_hold: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    dma_req_vld && !dma_req_rdy |=> $stable(dma_req))
    else $error("dma_req changed while stalled");

  // ========================================
  // context queue and op control
  // ========================================
  no_write_full: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    req_accept |-> occupancy < ctx_depth)
    else $error("context queue written while full");

  // first request one cycle after the load
  load_to_vld: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    op_load |=> dma_req_vld)
    else $error("no request one cycle after op_load");

endmodule

// File: verification/sdp_rdma_ig_tb.sv
module sdp_rdma_ig_tb import sdp_rdma_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ctx_depth = 4;

  logic       autosa_core_clk = 1'b0;
  logic       autosa_core_rstn;
  logic       op_load;
  rdma_cfg_t  cfg;
  dma_req_t   dma_req;
  logic       dma_req_vld;
  logic       dma_req_rdy = 1'b0;
  ctx_entry_t ctx;
  logic       ctx_vld;
  logic       ctx_rdy = 1'b0;
  stall_cnt_t rdma_stall;

  // expected traffic, filled per op and popped by the monitor
  dma_req_t   exp_req[$];
  ctx_entry_t exp_ctx[$];
  stall_cnt_t stall_seen = '0;
  logic       rdy_random = 1'b0;
  logic       ctx_hold = 1'b0;
  int         acc_cnt = 0;
  int         req_err = 0;
  int         ctx_err = 0;
  int         other_err = 0;
  // margin, grows by 20 cycles per queued request
  int         limit_cycles = 200;
  int         cycles = 0;

  always #20 autosa_core_clk = ~autosa_core_clk;

  sdp_rdma_ig #(.ctx_depth(ctx_depth)) sdp_rdma_ig_inst (.*);

  bind sdp_rdma_ig sdp_rdma_ig_checker #(.ctx_depth(ctx_depth)) u_checker (.*);

  // ========================================
  // stimulus and monitor
  // ========================================
  always @(posedge autosa_core_clk) begin
    dma_req_rdy <= rdy_random ? 1'($urandom() % 2) : 1'b1;
    ctx_rdy     <= ~ctx_hold;
  end

  always @(posedge autosa_core_clk) begin
    if (autosa_core_rstn) begin
      // stall model, cleared by a load
      if (cfg.op_en && cfg.perf_dma_en) begin
        if (op_load) begin
          stall_seen = '0;
        end else if (dma_req_vld && !dma_req_rdy) begin
          stall_seen = stall_seen + 1'b1;
        end
      end
      if (dma_req_vld && dma_req_rdy) begin
        acc_cnt++;
        assert (exp_req.size() > 0) else begin
          other_err++;
          $display("request accepted at %0t with none expected", $time);
        end
        if (exp_req.size() > 0) begin
          assert (dma_req == exp_req[0]) else begin
            req_err++;
            $display("mismatch at %0t: dma_req got %h expected %h", $time, dma_req, exp_req[0]);
          end
          void'(exp_req.pop_front());
        end
      end
      if (ctx_vld && ctx_rdy) begin
        assert (exp_ctx.size() > 0) else begin
          other_err++;
          $display("context entry popped at %0t with none expected", $time);
        end
        if (exp_ctx.size() > 0) begin
          assert (ctx == exp_ctx[0]) else begin
            ctx_err++;
            $display("mismatch at %0t: ctx got %h expected %h", $time, ctx, exp_ctx[0]);
          end
          void'(exp_ctx.pop_front());
        end
      end
    end
  end

  // ========================================
  // reference model
  // ========================================
  task automatic push_exp(input dma_addr_t a, input dma_size_t s, input logic last);
    exp_req.push_back({a, s});
    exp_ctx.push_back({last, s});
  endtask

  task automatic expect_op(input rdma_cfg_t c);
    int        m;
    int        groups;
    int        n;
    dma_size_t w_size;
    dma_size_t s_size;
    // element multiplier from precision, data size and data use
    if (c.precision == int8) begin
      groups = int'(c.channel) / 8;
      m = c.data_use_both ? (c.data_size_1byte ? 2 : 4) : (c.data_size_1byte ? 1 : 2);
    end else begin
      groups = int'(c.channel) / 4;
      m = c.data_use_both ? 2 : 1;
    end
    w_size = dma_size_t'((int'(c.width) + 1) * m - 1);
    s_size = dma_size_t'((groups + 1) * m - 1);
    n = 0;
    if (c.data_mode_per_kernel || (c.width == 0 && c.height == 0)) begin
      push_exp(dma_addr_t'(c.base_addr) * 8, s_size, 1'b1);
      n = 1;
    end else begin
      // channel group outer, line inner
      for (int k = 0; k <= groups; k++) begin
        for (int h = 0; h <= int'(c.height); h++) begin
          push_exp(dma_addr_t'((c.base_addr + k * c.surf_stride + h * c.line_stride) * 8),
                   w_size, (k == groups) && (h == int'(c.height)));
          n++;
        end
      end
    end
    limit_cycles += n * 20;
  endtask

  function automatic rdma_cfg_t make_cfg(input precision_e p, input logic per_kernel,
                                         input logic one_byte, input logic both,
                                         input int ch, input int ht, input int wd);
    rdma_cfg_t c;
    c = '0;
    c.op_en                = 1'b1;
    c.perf_dma_en          = 1'b1;
    c.precision            = p;
    c.data_mode_per_kernel = per_kernel;
    c.data_size_1byte      = one_byte;
    c.data_use_both        = both;
    c.channel              = dim_t'(ch);
    c.height               = dim_t'(ht);
    c.width                = dim_t'(wd);
    c.base_addr            = 29'h0040;
    c.line_stride          = 29'h0010;
    c.surf_stride          = 29'h0100;
    return c;
  endfunction

  // ========================================
  // op control and tests
  // ========================================
  task automatic run_op(input rdma_cfg_t c);
    expect_op(c);
    @(posedge autosa_core_clk);
    cfg     <= c;
    op_load <= 1'b1;
    @(posedge autosa_core_clk);
    op_load <= 1'b0;
  endtask

  // last accept and last pop seen, then valid must be low
  task automatic wait_drain();
    while (exp_req.size() != 0 || exp_ctx.size() != 0) begin
      @(posedge autosa_core_clk);
    end
    @(posedge autosa_core_clk);
    assert (!dma_req_vld) else begin
      other_err++;
      $display("dma_req_vld still high after the cube end at %0t", $time);
    end
  endtask

  task automatic check_stall();
    assert (rdma_stall == stall_seen) else begin
      other_err++;
      $display("mismatch at %0t: rdma_stall got %0d expected %0d", $time, rdma_stall, stall_seen);
    end
  endtask

  task automatic test_line_mode();
    run_op(make_cfg(int8, 1'b0, 1'b1, 1'b0, 15, 2, 7));
    wait_drain();
    run_op(make_cfg(int16, 1'b0, 1'b1, 1'b1, 11, 1, 3));
    wait_drain();
  endtask

  task automatic test_per_kernel();
    run_op(make_cfg(int8, 1'b1, 1'b0, 1'b1, 31, 3, 5));
    wait_drain();
  endtask

  task automatic test_pack_1x1();
    run_op(make_cfg(int16, 1'b0, 1'b0, 1'b0, 7, 0, 0));
    wait_drain();
  endtask

  task automatic test_random_ready();
    rdy_random <= 1'b1;
    run_op(make_cfg(int8, 1'b0, 1'b0, 1'b0, 15, 2, 4));
    wait_drain();
    check_stall();
    // count restarts from the second load
    run_op(make_cfg(int16, 1'b0, 1'b1, 1'b0, 7, 1, 2));
    wait_drain();
    check_stall();
    rdy_random <= 1'b0;
  endtask

  task automatic test_ctx_full();
    int base;
    base = acc_cnt;
    ctx_hold <= 1'b1;
    run_op(make_cfg(int8, 1'b0, 1'b1, 1'b0, 15, 3, 5));
    while (acc_cnt - base < ctx_depth) begin
      @(posedge autosa_core_clk);
    end
    // queue full, walker has to sit still
    repeat (4) @(posedge autosa_core_clk);
    assert (acc_cnt - base == ctx_depth && !dma_req_vld) else begin
      other_err++;
      $display("full context queue did not hold back requests, %0d accepted", acc_cnt - base);
    end
    ctx_hold <= 1'b0;
    wait_drain();
  endtask

  task automatic end_run();
    $display("request errors %0d, context errors %0d, other errors %0d",
             req_err, ctx_err, other_err);
    if (req_err + ctx_err + other_err == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(32'h9af0_6773));
    autosa_core_rstn = 1'b0;
    op_load          = 1'b0;
    cfg              = '0;
    repeat (2) @(posedge autosa_core_clk);
    autosa_core_rstn <= 1'b1;
    @(posedge autosa_core_clk);
    assert (!dma_req_vld && !ctx_vld && rdma_stall == '0) else begin
      other_err++;
      $display("outputs not cleared by reset");
    end
    test_line_mode();
    test_per_kernel();
    test_pack_1x1();
    test_random_ready();
    test_ctx_full();
    end_run();
  end

  // watchdog
  initial begin
    while (cycles <= limit_cycles) begin
      @(posedge autosa_core_clk);
      cycles++;
    end
    other_err++;
    $display("timeout after %0d cycles, %0d requests never seen", cycles, exp_req.size());
    end_run();
  end

endmodule

// File: vlog.f
rtl/sdp_rdma_pkg.sv
rtl/sdp_rdma_cube_walker.sv
rtl/sdp_rdma_ctx_fifo.sv
rtl/sdp_rdma_ig.sv
verification/sdp_rdma_ig_checker.sv
verification/sdp_rdma_ig_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= sdp_rdma_ig_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass search on the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
